/* Makefile */
# Verilator build and run of the console testbench

VERILATOR ?= verilator
TOP       ?= tb_fake_console
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* boot_script_rom.sv */
//------------------------------
// canned keystroke scripts
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module boot_script_rom (
   script_if.store rom
);
   console_pkg::char_t       ch;
   console_pkg::script_idx_t len; // characters in the selected script

   always_comb begin
      ch  = 8'h0d; // return unless a script says otherwise
      case (rom.sel)
         2'd0: begin // rt11 directory
            len = 5'd4;
            case (rom.idx)
               5'd0:    ch = 8'h64; // d
               5'd1:    ch = 8'h69; // i
               5'd2:    ch = 8'h72; // r
               default: ch = 8'h0d;
            endcase
         end
         2'd1: begin // v6 boot line
            len = 5'd10;
            case (rom.idx)
               5'd0:    ch = 8'h72; // r
               5'd1:    ch = 8'h6b; // k
               5'd2:    ch = 8'h75; // u
               5'd3:    ch = 8'h6e; // n
               5'd4:    ch = 8'h69; // i
               5'd5:    ch = 8'h78; // x
               5'd6:    ch = 8'h2e; // .
               5'd7:    ch = 8'h34; // 4
               5'd8:    ch = 8'h30; // 0
               default: ch = 8'h0d;
            endcase
         end
         2'd2: begin // test line, then ^C
            len = 5'd17;
            case (rom.idx)
               5'd0, 5'd10:        ch = 8'h74; // t
               5'd1:               ch = 8'h68; // h
               5'd2, 5'd5:         ch = 8'h69; // i
               5'd3, 5'd6, 5'd12:  ch = 8'h73; // s
               5'd4, 5'd7, 5'd9:   ch = 8'h20; // space
               5'd8:               ch = 8'h61; // a
               5'd11:              ch = 8'h65; // e
               5'd13:              ch = 8'h74; // t
               5'd15:              ch = 8'h0a; // lf
               5'd16:              ch = 8'h03; // ^C
               default:            ch = 8'h0d;
            endcase
         end
         default: begin // select 3 is three returns
            len = 5'd3;
         end
      endcase
   end

   assign rom.char = ch;
   assign rom.last = (rom.idx >= len - 5'd1); // also set past the end
endmodule

`default_nettype wire

/* console_consts.svh */
//------------------------------
// console timing constants and
// script count
//------------------------------
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

`define CON_INIT_DELAY 20 // start to first character
`define CON_CHAR_GAP   12 // unload to next character
`define CON_TX_BUSY    8  // transmitter busy time
`define CON_SCRIPTS    4  // canned scripts in the rom

`endif

/* console_pkg.sv */
//------------------------------
// console package: character,
// script, counter and port types
//------------------------------
`default_nettype none

package console_pkg;

   typedef logic [7:0] char_t;       // one console character
   typedef logic [1:0] script_sel_t; // 0 rt11 dir, 1 v6 boot, 2 test line, 3 returns
   typedef logic [4:0] script_idx_t; // position inside a script
   typedef logic [7:0] delay_t;      // pacing and busy counters

   // four-phase request/acknowledge port
   typedef enum logic [1:0] {
      hs_idle,
      hs_held,
      hs_release
   } hs_state_t;

endpackage

`default_nettype wire

/* fake_console.sv */
//------------------------------
// simulation console top level
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module fake_console (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  console_pkg::script_sel_t script_sel,
   input  logic                     rx_req,
   output logic                     rx_ack,
   output console_pkg::char_t       rx_data,
   output logic                     rx_empty,
   output logic                     script_done,
   input  logic                     tx_req,
   output logic                     tx_ack,
   input  console_pkg::char_t       tx_data,
   output logic                     tx_empty,
   output console_pkg::char_t       tx_char,
   output logic                     tx_strobe
);
   logic rx_xfer; // unload strobe
   logic tx_xfer; // load strobe

   script_if rom_bus ();

   req_ack_port u_rx_port (
      .clk   (clk),
      .reset (reset),
      .req   (rx_req),
      .ack   (rx_ack),
      .xfer  (rx_xfer)
   );

   req_ack_port u_tx_port (
      .clk   (clk),
      .reset (reset),
      .req   (tx_req),
      .ack   (tx_ack),
      .xfer  (tx_xfer)
   );

   rx_injector u_rx_injector (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .script_sel  (script_sel),
      .xfer        (rx_xfer),
      .rx_data     (rx_data),
      .rx_empty    (rx_empty),
      .script_done (script_done),
      .rom         (rom_bus.reader)
   );

   boot_script_rom u_rom (
      .rom (rom_bus.store)
   );

   tx_sink u_tx_sink (
      .clk       (clk),
      .reset     (reset),
      .xfer      (tx_xfer),
      .tx_data   (tx_data),
      .tx_empty  (tx_empty),
      .tx_char   (tx_char),
      .tx_strobe (tx_strobe)
   );
endmodule

`default_nettype wire

/* files.f */
+incdir+.
console_pkg.sv
script_if.sv
boot_script_rom.sv
req_ack_port.sv
rx_injector.sv
tx_sink.sv
fake_console.sv
tb_fake_console.sv

/* req_ack_port.sv */
//------------------------------
// four-phase req/ack port
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module req_ack_port (
   input  logic clk,
   input  logic reset,
   input  logic req,
   output logic ack,
   output logic xfer
);
   console_pkg::hs_state_t state;
   console_pkg::hs_state_t state_next;

   always_comb begin
      state_next = state;
      case (state)
         console_pkg::hs_idle: begin
            if (req) state_next = console_pkg::hs_held;
         end
         console_pkg::hs_held: begin
            if (!req) state_next = console_pkg::hs_release; // host dropped req
         end
         default: state_next = console_pkg::hs_idle;
      endcase
   end

   // one-cycle strobe on the idle to held edge
   assign xfer = (state == console_pkg::hs_idle) && req;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= console_pkg::hs_idle;
         ack   <= 1'b0;
      end else begin
         state <= state_next;
         ack   <= (state == console_pkg::hs_held); // one edge behind the state
      end
   end
endmodule

`default_nettype wire

/* rx_injector.sv */
//------------------------------
// receive side: holding cell,
// script position and pacing
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module rx_injector (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  console_pkg::script_sel_t script_sel,
   input  logic                     xfer,
   output console_pkg::char_t       rx_data,
   output logic                     rx_empty,
   output logic                     script_done,
   script_if.reader                 rom
);
   console_pkg::char_t  hold;    // holding cell
   console_pkg::delay_t delay;   // cycles left before the next fill
   logic                running; // set by the first start
   logic                fill;
   logic                unload;

   assign fill   = running && rx_empty && !script_done && (delay == '0);
   assign unload = xfer && !rx_empty; // unload of an empty cell is ignored

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rom.sel     <= '0;
         rom.idx     <= '0;
         delay       <= '0;
         running     <= 1'b0;
         rx_empty    <= 1'b1;
         script_done <= 1'b0;
      end else if (start) begin
         // restart from the top of the selected script
         rom.sel     <= script_sel;
         rom.idx     <= '0;
         delay       <= console_pkg::delay_t'(`CON_INIT_DELAY);
         running     <= 1'b1;
         rx_empty    <= 1'b1;
         script_done <= 1'b0;
      end else if (unload) begin
         rx_empty <= 1'b1;
         delay    <= console_pkg::delay_t'(`CON_CHAR_GAP); // gap before next char
      end else if (fill) begin
         rx_empty    <= 1'b0;
         rom.idx     <= rom.idx + 5'd1;
         script_done <= rom.last;
      end else if (rx_empty && (delay != '0)) begin
         delay <= delay - 8'd1; // run down only while the cell is empty
      end
   end

   // cell and output character
   always_ff @(posedge clk) begin
      if (fill) begin
         hold <= rom.char;
      end
      if (unload) begin
         rx_data <= hold;
      end
   end
endmodule

`default_nettype wire

/* script_if.sv */
//------------------------------
// script store lookup interface
//------------------------------
`timescale 1ns/100ps
`default_nettype none

interface script_if;
   console_pkg::script_sel_t sel;  // latched script select
   console_pkg::script_idx_t idx;  // position in the script
   console_pkg::char_t       char; // character at sel/idx
   logic                     last; // final character of the script

   modport store (
      input  sel,
      input  idx,
      output char,
      output last
   );

   modport reader (
      output sel,
      output idx,
      input  char,
      input  last
   );
endinterface

`default_nettype wire

/* tb_fake_console.sv */
//------------------------------
// testbench for the simulation
// console: scripts, pacing, echo
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module tb_fake_console;
   localparam int RX_ACK   = 0;
   localparam int TX_ACK   = 1;
   localparam int RX_EMPTY = 2;
   localparam int TX_EMPTY = 3;

   logic                     clk;
   logic                     reset;
   logic                     start;
   console_pkg::script_sel_t script_sel;
   logic                     rx_req, rx_ack, rx_empty, script_done;
   logic                     tx_req, tx_ack, tx_empty, tx_strobe;
   console_pkg::char_t       rx_data, tx_data, tx_char;
   logic [31:0]              lcg_state = 32'hf243_3871;
   console_pkg::char_t       tx_expect[$];   // loaded bytes not yet echoed
   int                       tx_strobes = 0;
   int                       pace_cycles;    // cycles since start or unload
   int                       pace_min;
   string                    pace_name;
   logic                     pace_armed, empty_last, req_last;

   fake_console UUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int rand_range(input int n);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return int'(lcg_state[23:8]) % n;
   endfunction

   // expected {last, character} of each canned script
   function automatic logic [8:0] script_char(input console_pkg::script_sel_t sel, input int idx);
      string text;
      case (sel)
         2'd0:    text = "dir\015";
         2'd1:    text = "rkunix.40\015";
         2'd2:    text = "this is a test\015\012\003";
         default: text = "\015\015\015";
      endcase
      if (idx >= text.len()) return {1'b1, 8'h0d};
      return {(idx == text.len() - 1), text.getc(idx)};
   endfunction

   function automatic int script_length(input console_pkg::script_sel_t sel);
      logic [8:0] ent;
      int         n;
      n = 0;
      ent = script_char(sel, 0);
      while (!ent[8]) begin
         n++;
         ent = script_char(sel, n);
      end
      return n + 1;
   endfunction

   task automatic stop_run();
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_char(input string name, input console_pkg::char_t exp,
                             input console_pkg::char_t act);
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input int lo, input int hi, input int act);
      if (act < lo || act > hi) begin
         $display("ERR %s: expected %0d..%0d, actual %0d", name, lo, hi, act);
         stop_run();
      end
   endtask

   function automatic logic watched(input int which);
      case (which)
         RX_ACK:   return rx_ack;
         TX_ACK:   return tx_ack;
         RX_EMPTY: return rx_empty;
         default:  return tx_empty;
      endcase
   endfunction

   task automatic wait_level(input string what, input int which, input logic level,
                             input int limit, output int cycles);
      cycles = 0;
      while (watched(which) !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > limit) begin
            $display("timeout: waited %0d cycles for %s", limit, what);
            stop_run();
         end
      end
   endtask

   task automatic start_script(input console_pkg::script_sel_t sel);
      script_sel = sel;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic rx_unload(input int max_pause, output console_pkg::char_t got);
      int c;
      rx_req = 1'b1;
      wait_level("rx_ack to rise", RX_ACK, 1'b1, 4, c);
      got = rx_data; // valid while ack is high
      repeat (rand_range(max_pause + 1)) @(negedge clk);
      rx_req = 1'b0;
      wait_level("rx_ack to fall", RX_ACK, 1'b0, 4, c);
      repeat (rand_range(max_pause + 1)) @(negedge clk);
   endtask

   task automatic tx_load(input console_pkg::char_t b, input int max_pause, output int cycles);
      int c;
      int p;
      tx_data = b;
      tx_req = 1'b1;
      wait_level("tx_ack to rise", TX_ACK, 1'b1, 4, c);
      p = rand_range(max_pause + 1);
      repeat (p) @(negedge clk);
      cycles = c + p;
      tx_req = 1'b0;
      wait_level("tx_ack to fall", TX_ACK, 1'b0, 4, c);
      p = rand_range(max_pause + 1);
      repeat (p) @(negedge clk);
      cycles += c + p;
   endtask

   task automatic run_script(input console_pkg::script_sel_t sel);
      logic [8:0]         want;
      console_pkg::char_t got;
      console_pkg::char_t held;
      logic               last_seen;
      int                 n;
      int                 c;
      n = 0;
      start_script(sel);
      do begin
         wait_level("rx_empty to fall", RX_EMPTY, 1'b0, `CON_INIT_DELAY + `CON_CHAR_GAP, c);
         want = script_char(sel, n);
         last_seen = script_done;
         rx_unload(3, got);
         check_char($sformatf("script %0d char %0d", sel, n), want[7:0], got);
         n++;
      end while (!last_seen && n < 32);
      check_count($sformatf("script %0d length", sel), script_length(sel), script_length(sel), n);
      check_flag("done after last char", 1'b1, script_done);
      held = want[7:0];
      repeat (3 * `CON_CHAR_GAP) begin
         @(negedge clk);
         check_flag("cell empty after done", 1'b1, rx_empty);
      end
      rx_unload(1, got); // cell is empty so rx_data must hold
      check_char("unload of empty cell", held, got);
   endtask

   // pacing monitor reads the values held just before each rising edge
   always @(posedge clk) begin
      if (reset) begin
         pace_armed = 1'b0;
         pace_cycles = 0;
         pace_min = 0;
         empty_last = 1'b1;
         req_last = 1'b0;
      end else begin
         if (pace_armed && empty_last && !rx_empty) begin
            check_count(pace_name, pace_min, pace_min + 2, pace_cycles);
         end
         if (start) begin
            pace_armed = 1'b1;
            pace_cycles = 0;
            pace_min = `CON_INIT_DELAY;
            pace_name = "rx pacing after start";
         end else if (rx_req && !req_last && !rx_empty) begin
            pace_cycles = 0; // unload of a full cell
            pace_min = `CON_CHAR_GAP;
            pace_name = "rx pacing after unload";
         end else begin
            pace_cycles++;
         end
         empty_last = rx_empty;
         req_last = rx_req;
      end
   end

   // echo checker
   always @(negedge clk) begin
      console_pkg::char_t want;
      if (!reset && tx_strobe) begin
         if (tx_expect.size() == 0) begin
            $display("tx_strobe pulsed with no loaded byte left to echo");
            stop_run();
         end else begin
            want = tx_expect.pop_front();
            check_char("tx echo", want, tx_char);
            tx_strobes++;
         end
      end
   end

   initial begin
      logic [8:0]         want;
      console_pkg::char_t b;
      console_pkg::char_t got;
      int                 c1, c2, c3;
      reset = 1'b1;
      start = 1'b0;
      script_sel = '0;
      rx_req = 1'b0;
      tx_req = 1'b0;
      tx_data = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_flag("rx_empty after reset", 1'b1, rx_empty);
      check_flag("tx_empty after reset", 1'b1, tx_empty);
      check_flag("rx_ack after reset", 1'b0, rx_ack);
      check_flag("tx_ack after reset", 1'b0, tx_ack);
      check_flag("tx_strobe after reset", 1'b0, tx_strobe);
      check_flag("script_done after reset", 1'b0, script_done);

      for (int s = 0; s < `CON_SCRIPTS; s++) begin
         run_script(console_pkg::script_sel_t'(s));
      end

      // restart in the middle of script 2
      start_script(2'd2);
      for (int i = 0; i < 5; i++) begin
         wait_level("rx_empty to fall", RX_EMPTY, 1'b0, `CON_INIT_DELAY + `CON_CHAR_GAP, c1);
         rx_unload(2, got);
         want = script_char(2'd2, i);
         check_char($sformatf("script 2 char %0d before restart", i), want[7:0], got);
      end
      wait_level("rx_empty to fall", RX_EMPTY, 1'b0, `CON_INIT_DELAY + `CON_CHAR_GAP, c1);
      start_script(2'd0); // a character is still in the cell
      check_flag("done cleared by restart", 1'b0, script_done);
      check_flag("cell emptied by restart", 1'b1, rx_empty);
      wait_level("rx_empty to fall", RX_EMPTY, 1'b0, `CON_INIT_DELAY + `CON_CHAR_GAP, c1);
      rx_unload(2, got);
      want = script_char(2'd0, 0);
      check_char("first char after restart", want[7:0], got);
      check_flag("done after restart", 1'b0, script_done);

      // transmit loads and echo
      for (int i = 0; i < 20; i++) begin
         wait_level("tx_empty to rise", TX_EMPTY, 1'b1, `CON_TX_BUSY + 4, c1);
         b = console_pkg::char_t'(rand_range(256));
         tx_expect.push_back(b);
         tx_load(b, 3, c1);
      end
      wait_level("tx_empty to rise", TX_EMPTY, 1'b1, `CON_TX_BUSY + 4, c1);
      b = console_pkg::char_t'(rand_range(256));
      tx_expect.push_back(b);
      tx_load(b, 0, c1);
      check_flag("tx busy at second load", 1'b0, tx_empty);
      tx_load(~b, 0, c2); // dropped with no echo
      wait_level("tx_empty to rise", TX_EMPTY, 1'b1, `CON_TX_BUSY + 4, c3);
      check_count("tx busy time", 1, `CON_TX_BUSY + 2, c1 + c2 + c3);
      repeat (2) @(negedge clk);
      check_count("tx strobes", 21, 21, tx_strobes);
      check_count("tx bytes not echoed", 0, 0, tx_expect.size());

      $display("Verification passed");
      $finish;
   end
endmodule

`default_nettype wire

/* tx_sink.sv */
//------------------------------
// transmit sink: busy timer
// and character echo
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module tx_sink (
   input  logic               clk,
   input  logic               reset,
   input  logic               xfer,
   input  console_pkg::char_t tx_data,
   output logic               tx_empty,
   output console_pkg::char_t tx_char,
   output logic               tx_strobe
);
   console_pkg::delay_t busy; // busy cycles left
   logic                accept;

   assign accept = xfer && tx_empty; // a load while busy is lost

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy      <= '0;
         tx_empty  <= 1'b1;
         tx_strobe <= 1'b0;
      end else begin
         tx_strobe <= accept; // one-cycle echo strobe
         if (accept) begin
            tx_empty <= 1'b0;
            busy     <= console_pkg::delay_t'(`CON_TX_BUSY - 1);
         end else if (!tx_empty) begin
            if (busy == '0) begin
               tx_empty <= 1'b1;
            end else begin
               busy <= busy - 8'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         tx_char <= tx_data; // echoed character
      end
   end
endmodule

`default_nettype wire
